// File: build.f
+incdir+include
verilog/rx_dma_pkg.sv
verilog/rx_irq_gen.sv
verilog/rx_ring_tracker.sv
verilog/rx_host_regs.sv
verilog/rx_dma_irq_top.sv
testbench/rx_dma_irq_assert.sv
testbench/rx_dma_irq_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the rx dma interrupt path testbench with verilator and run it
# the run passes only when the pass message shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rx_dma_irq_tb -f build.f \
    || { echo "verilator build failed"; exit 1; }

sim_out=$(./obj_dir/Vrx_dma_irq_tb 2>&1)
echo "$sim_out"

echo "$sim_out" | grep -q "Test completed successfully" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

// File: testbench/rx_dma_irq_tb.sv
// testbench for the rx dma interrupt path
// clock, reset, apb and frame stimulus on the falling edge
// own ring pointer model fed by a seeded lcg
// readback checks, error counts and closing report
`include "rx_dma_settings.svh"

module rx_dma_irq_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int AW         = `APB_ADDR_W;
    localparam int DW         = `APB_DATA_W;
    localparam int CLK_HALF   = 20;     // 40 ns period
    localparam int WAIT_LIMIT = 40;     // cycles per bounded wait
    localparam int N_RANDOM   = 24;

    localparam logic [AW-1:0] A_CTRL   = AW'(`RX_REG_CTRL);
    localparam logic [AW-1:0] A_SW_PTR = AW'(`RX_REG_SW_PTR);
    localparam logic [AW-1:0] A_HW_PTR = AW'(`RX_REG_HW_PTR);
    localparam logic [AW-1:0] A_STATUS = AW'(`RX_REG_STATUS);
    localparam logic [AW-1:0] A_BAD    = AW'('h10);     // first unmapped offset
    localparam logic [DW-1:0] SW_MASK  =
        DW'(`RX_RING_BYTES - 1) & ~DW'(`RX_ALIGN_BYTES - 1);

    localparam logic [DW-1:0] ST_IDLE   = DW'(rx_dma_pkg::irq_idle);
    localparam logic [DW-1:0] ST_WAIT   = DW'(rx_dma_pkg::irq_wait_activity);
    localparam logic [DW-1:0] ST_ACTIVE = DW'(rx_dma_pkg::irq_active);

    logic                 clk;
    logic                 rst;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [AW-1:0]        paddr;
    logic [DW-1:0]        pwdata;
    logic [DW-1:0]        prdata;
    logic                 pready;
    logic                 pslverr;
    logic                 frame_done;
    logic [`RX_LEN_W-1:0] frame_len;
    logic                 mac_activity;
    logic                 send_irq;

    logic [31:0] lcg_state;     // seeded at start
    logic [31:0] model_hw;      // expected hw write pointer
    int unsigned n_err;
    int unsigned n_timeout;

    rx_dma_irq_top u_dut (
        .clk, .rst,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .frame_done, .frame_len, .mac_activity,
        .send_irq
    );

    bind rx_dma_irq_top rx_dma_irq_assert u_chk (
        .clk, .rst, .mac_activity, .send_irq, .hst_rdy,
        .hw_ptr, .sw_ptr, .irq_state
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // length rounded up to whole slots
    function automatic logic [31:0] slot_bytes(input logic [`RX_LEN_W-1:0] len);
        return ((32'(len) + `RX_ALIGN_BYTES - 1) / `RX_ALIGN_BYTES) * `RX_ALIGN_BYTES;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            n_err++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic finish_run();
        int unsigned n_assert;
        n_assert = u_dut.u_chk.n_fail;
        $display("errors: %0d checks, %0d assertions, %0d timeouts", n_err, n_assert, n_timeout);
        if (n_err == 0 && n_assert == 0 && n_timeout == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        n_timeout++;
        $display("timeout while waiting for %s", what);
        finish_run();
    endtask

    // setup then access, sampled mid low phase
    task automatic apb_xfer(input logic wr, input logic [AW-1:0] addr, input logic [DW-1:0] wdata,
                            output logic [DW-1:0] rdata, output logic err);
        int n;
        @(negedge clk);
        psel   = 1'b1;
        pwrite = wr;
        paddr  = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_HALF / 2);
        n = 0;
        while (!pready && n < WAIT_LIMIT) begin
            @(negedge clk);
            #(CLK_HALF / 2);
            n++;
        end
        if (!pready) begin
            timed_out("apb pready");
        end else begin
            check_val("apb wait states", 32'd0, 32'(n));   // no wait states allowed
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input string name, input logic [AW-1:0] addr,
                             input logic [DW-1:0] data, input logic exp_err);
        logic [DW-1:0] rd;
        logic          err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_val({name, " pslverr"}, 32'(exp_err), 32'(err));
    endtask

    task automatic apb_read(input string name, input logic [AW-1:0] addr,
                            input logic [DW-1:0] exp_data, input logic exp_err);
        logic [DW-1:0] rd;
        logic          err;
        apb_xfer(1'b0, addr, '0, rd, err);
        check_val({name, " pslverr"}, 32'(exp_err), 32'(err));
        if (!exp_err) begin
            check_val(name, exp_data, rd);
        end
    endtask

    task automatic send_frame(input logic [`RX_LEN_W-1:0] len);
        @(negedge clk);
        frame_done = 1'b1;
        frame_len  = len;
        @(negedge clk);
        frame_done = 1'b0;
        frame_len  = '0;
        model_hw = (model_hw + slot_bytes(len)) % `RX_RING_BYTES;    // wrap at ring end
    endtask

    task automatic pulse_activity();
        @(negedge clk);
        mac_activity = 1'b1;
        @(negedge clk);
        mac_activity = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_irq(input logic level, input string what);
        int n;
        n = 0;
        while (send_irq !== level && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (send_irq !== level) begin
            timed_out(what);
        end
    endtask

    // host reads hw_ptr and moves its read pointer there
    task automatic catch_up(input string name);
        logic [DW-1:0] hw;
        logic          err;
        apb_xfer(1'b0, A_HW_PTR, '0, hw, err);
        check_val({name, " hw_ptr"}, model_hw, hw);
        apb_write({name, " sw_ptr"}, A_SW_PTR, hw, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    initial begin
        logic [31:0]          r;
        logic [`RX_LEN_W-1:0] len;
        rst          = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        frame_done   = 1'b0;
        frame_len    = '0;
        mac_activity = 1'b0;
        n_err        = 0;
        n_timeout    = 0;
        lcg_state    = 32'd71;
        model_hw     = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // traffic before arming stays silent
        apb_read("status after reset", A_STATUS, ST_IDLE, 1'b0);
        pulse_activity();
        send_frame(16'd60);
        send_frame(16'd100);
        idle_cycles(4);
        check_val("irq before arming", 32'd0, 32'(send_irq));
        apb_read("status before arming", A_STATUS, ST_IDLE, 1'b0);

        // arm, then first activity
        apb_write("arm host_ready", A_CTRL, 32'd1, 1'b0);
        apb_read("ctrl armed", A_CTRL, 32'd1, 1'b0);
        apb_read("status armed", A_STATUS, ST_WAIT, 1'b0);
        pulse_activity();
        wait_irq(1'b1, "first interrupt");
        apb_read("status active", A_STATUS, ST_ACTIVE, 1'b0);

        // level rule, pointers and activity
        catch_up("catch up 1");
        wait_irq(1'b0, "irq drop after catch up");
        send_frame(16'd64);
        wait_irq(1'b1, "irq on new frame");
        catch_up("catch up 2");
        wait_irq(1'b0, "irq drop after second catch up");
        pulse_activity();
        wait_irq(1'b1, "irq on activity");
        wait_irq(1'b0, "irq drop after activity");

        // random lengths around the ring
        for (int i = 0; i < N_RANDOM; i++) begin
            r = lcg_next();
            if (r[30:28] == 3'd0) begin
                len = '0;
            end else begin
                len = 16'(r[26:16]);        // up to 2047 bytes
            end
            send_frame(len);
            if (i % 4 == 3) begin
                catch_up("random frames");
            end
        end
        send_frame(16'd0);
        apb_read("hw_ptr zero length", A_HW_PTR, model_hw, 1'b0);
        send_frame(16'd4093);                // one whole ring lap
        apb_read("hw_ptr full lap", A_HW_PTR, model_hw, 1'b0);

        // error responses leave registers alone
        apb_write("write hw_ptr", A_HW_PTR, 32'h0000_0ff8, 1'b1);
        apb_read("hw_ptr unchanged", A_HW_PTR, model_hw, 1'b0);
        apb_write("write status", A_STATUS, 32'd0, 1'b1);
        apb_read("status unchanged", A_STATUS, ST_ACTIVE, 1'b0);
        apb_write("sw_ptr masked write", A_SW_PTR, 32'h1234_5677, 1'b0);
        apb_read("read unmapped", A_BAD, '0, 1'b1);
        apb_write("write unmapped", A_BAD, 32'hffff_fff0, 1'b1);    // bit 0 low, would clear ctrl
        apb_read("sw_ptr masked", A_SW_PTR, 32'h1234_5677 & SW_MASK, 1'b0);
        apb_read("ctrl unchanged", A_CTRL, 32'd1, 1'b0);

        // host_ready cleared, fsm stays active
        apb_write("clear host_ready", A_CTRL, 32'd0, 1'b0);
        apb_read("ctrl cleared", A_CTRL, 32'd0, 1'b0);
        apb_read("status after clear", A_STATUS, ST_ACTIVE, 1'b0);
        idle_cycles(2);
        finish_run();
    end

endmodule

// File: testbench/rx_dma_irq_assert.sv
// bound checker for the rx dma interrupt path
// interrupt line silent until the fsm is active
// arming, first activity latency and level rule
// fsm never disarms, ring pointers aligned and in range
`include "rx_dma_settings.svh"

module rx_dma_irq_assert (
    input logic                      clk,
    input logic                      rst,
    input logic                      mac_activity,   // async, raw
    input logic                      send_irq,
    input logic                      hst_rdy,
    input logic [`RX_PTR_W-1:0]      hw_ptr,
    input logic [`RX_PTR_W-1:0]      sw_ptr,
    input rx_dma_pkg::rx_irq_state_e irq_state
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PTR_W = `RX_PTR_W;
    localparam logic [PTR_W-1:0] ALIGN_LSB = PTR_W'(`RX_ALIGN_BYTES - 1);
    localparam logic [PTR_W-1:0] RING_TOP  = PTR_W'(`RX_RING_BYTES);

    int unsigned n_fail = 0;    // failed assertions so far

    logic sync_meta;    // own copy of the two flop activity sync
    logic sync_q;
    logic lvl_q;        // expected line one cycle later in irq_active

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_meta <= 1'b0;
            sync_q    <= 1'b0;
            lvl_q     <= 1'b0;
        end else begin
            sync_meta <= mac_activity;
            sync_q    <= sync_meta;
            lvl_q     <= sync_q | (hw_ptr != sw_ptr);   // activity or unread data
        end
    end

    ////////////////////////////////////////////////////////////
    // interrupt fsm rules
    ////////////////////////////////////////////////////////////
    a_quiet_unarmed: assert property (@(posedge clk) disable iff (rst)
        (irq_state != rx_dma_pkg::irq_active) |-> !send_irq)
        else begin n_fail++; $error("send_irq high outside irq_active"); end

    a_arm: assert property (@(posedge clk) disable iff (rst)
        (irq_state == rx_dma_pkg::irq_idle && hst_rdy) |=>
            (irq_state == rx_dma_pkg::irq_wait_activity))
        else begin n_fail++; $error("host_ready did not arm the fsm"); end

    // first activity sample, sync empty, three edges to the line
    a_first_act: assert property (@(posedge clk) disable iff (rst)
        $past(irq_state == rx_dma_pkg::irq_wait_activity && mac_activity &&
              !sync_meta && !sync_q, 3) |-> (send_irq && irq_state == rx_dma_pkg::irq_active))
        else begin n_fail++; $error("send_irq not raised three edges after activity"); end

    a_level: assert property (@(posedge clk) disable iff (rst)
        (irq_state == rx_dma_pkg::irq_active) |=> (send_irq == lvl_q))
        else begin n_fail++; $error("send_irq does not follow activity and pointers"); end

    a_hold_active: assert property (@(posedge clk) disable iff (rst)
        (irq_state == rx_dma_pkg::irq_active && !hst_rdy) |=>
            (irq_state == rx_dma_pkg::irq_active))
        else begin n_fail++; $error("clearing host_ready left irq_active"); end

    a_no_disarm: assert property (@(posedge clk) disable iff (rst)
        (irq_state != rx_dma_pkg::irq_idle) |=> (irq_state != rx_dma_pkg::irq_idle))
        else begin n_fail++; $error("fsm went back to irq_idle without reset"); end

    ////////////////////////////////////////////////////////////
    // ring pointers
    ////////////////////////////////////////////////////////////
    a_hw_ptr_range: assert property (@(posedge clk) disable iff (rst)
        ((hw_ptr & ALIGN_LSB) == '0) && (hw_ptr < RING_TOP))
        else begin n_fail++; $error("hw_ptr unaligned or outside the ring"); end

    a_sw_ptr_range: assert property (@(posedge clk) disable iff (rst)
        ((sw_ptr & ALIGN_LSB) == '0) && (sw_ptr < RING_TOP))
        else begin n_fail++; $error("sw_ptr unaligned or outside the ring"); end

endmodule

// File: verilog/rx_dma_irq_top.sv
// rx dma interrupt path top level
// apb register block, ring write pointer tracker
// and interrupt generator wired together
`include "rx_dma_settings.svh"

module rx_dma_irq_top (
    input  logic                   clk,
    input  logic                   rst,
    // apb slave
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic [`APB_DATA_W-1:0] pwdata,
    output logic [`APB_DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    // dma writer and mac
    input  logic                   frame_done,
    input  logic [`RX_LEN_W-1:0]   frame_len,
    input  logic                   mac_activity,   // async
    output logic                   send_irq
);

    logic                      hst_rdy;    // ctrl.host_ready
    logic [`RX_PTR_W-1:0]      sw_ptr;     // host read pointer
    logic [`RX_PTR_W-1:0]      hw_ptr;     // ring write pointer
    rx_dma_pkg::rx_irq_state_e irq_state;  // for status readback

    ////////////////////////////////////////////////////////////
    // instances
    ////////////////////////////////////////////////////////////
    rx_host_regs u_regs (
        .clk, .rst,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .hw_ptr, .irq_state,
        .hst_rdy, .sw_ptr
    );

    rx_ring_tracker u_ring (
        .clk, .rst,
        .frame_done, .frame_len,
        .hw_ptr
    );

    rx_irq_gen u_irq (
        .clk, .rst,
        .mac_activity, .hst_rdy,
        .hw_ptr, .sw_ptr,
        .send_irq, .irq_state
    );

endmodule

// File: verilog/rx_host_regs.sv
// rx dma host register block
// apb slave without wait states
// ctrl and software pointer registers
// readback of both pointers and the irq fsm state
// pslverr on unmapped offsets and read only writes
`include "rx_dma_settings.svh"

module rx_host_regs (
    input  logic                            clk,
    input  logic                            rst,
    // apb slave
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [`APB_ADDR_W-1:0]          paddr,
    input  logic [`APB_DATA_W-1:0]          pwdata,
    output logic [`APB_DATA_W-1:0]          prdata,
    output logic                            pready,
    output logic                            pslverr,
    // status inputs
    input  logic [`RX_PTR_W-1:0]            hw_ptr,
    input  rx_dma_pkg::rx_irq_state_e       irq_state,
    // control outputs
    output logic                            hst_rdy,
    output logic [`RX_PTR_W-1:0]            sw_ptr
);

    localparam int AW    = `APB_ADDR_W;
    localparam int DW    = `APB_DATA_W;
    localparam int PTR_W = `RX_PTR_W;

    localparam logic [AW-1:0] A_CTRL   = AW'(`RX_REG_CTRL);
    localparam logic [AW-1:0] A_SW_PTR = AW'(`RX_REG_SW_PTR);
    localparam logic [AW-1:0] A_HW_PTR = AW'(`RX_REG_HW_PTR);
    localparam logic [AW-1:0] A_STATUS = AW'(`RX_REG_STATUS);

    // sw pointer is kept in ring range and slot aligned
    localparam logic [PTR_W-1:0] PTR_MASK =
        PTR_W'(`RX_RING_BYTES - 1) & ~PTR_W'(`RX_ALIGN_BYTES - 1);

    logic                     access;       // apb access phase
    logic                     hit_ctrl;
    logic                     hit_sw;
    logic                     hit_hw;
    logic                     hit_stat;
    logic                     mapped;       // any of the four registers
    logic                     ro_write;     // write to a read only reg
    rx_dma_pkg::rx_reg_word_u wr_word;      // pwdata seen through the union
    rx_dma_pkg::rx_reg_word_u rd_word;      // read data built through the union

    ////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////
    assign access   = psel & penable;
    assign hit_ctrl = (paddr == A_CTRL);
    assign hit_sw   = (paddr == A_SW_PTR);
    assign hit_hw   = (paddr == A_HW_PTR);
    assign hit_stat = (paddr == A_STATUS);
    assign mapped   = hit_ctrl | hit_sw | hit_hw | hit_stat;
    assign ro_write = pwrite & (hit_hw | hit_stat);

    assign pready  = 1'b1;                              // never stalls
    assign pslverr = access & (~mapped | ro_write);     // only in access phase

    assign wr_word = pwdata;

    ////////////////////////////////////////////////////////////
    // writable registers
    ////////////////////////////////////////////////////////////

    // written at the access cycle edge
    always_ff @(posedge clk) begin
        if (rst) begin
            hst_rdy <= 1'b0;
            sw_ptr  <= '0;
        end else if (access && pwrite) begin
            if (hit_ctrl) begin
                hst_rdy <= wr_word.ctrl.host_ready;     // reserved bits dropped
            end
            if (hit_sw) begin
                sw_ptr <= PTR_W'(wr_word.ptr) & PTR_MASK;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read mux
    ////////////////////////////////////////////////////////////

    // combinational, valid during the access cycle
    always_comb begin
        rd_word = '0;
        if (hit_ctrl) begin
            rd_word.ctrl.host_ready = hst_rdy;
        end
        if (hit_sw) begin
            rd_word.ptr = DW'(sw_ptr);
        end
        if (hit_hw) begin
            rd_word.ptr = DW'(hw_ptr);
        end
        if (hit_stat) begin
            rd_word.ptr = DW'(irq_state);       // state in the low two bits
        end
    end

    assign prdata = rd_word;

endmodule

// File: verilog/rx_ring_tracker.sv
// rx ring write pointer tracker
// advances the hw pointer once per finished frame
// frame length rounded up to the slot alignment
// pointer wraps at the end of the ring
`include "rx_dma_settings.svh"

module rx_ring_tracker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 frame_done,    // one cycle strobe
    input  logic [`RX_LEN_W-1:0] frame_len,     // bytes, valid with strobe
    output logic [`RX_PTR_W-1:0] hw_ptr
);

    localparam int PTR_W = `RX_PTR_W;

    // ring size and alignment are powers of two, so masks do the math
    localparam logic [PTR_W-1:0] RING_MASK  = PTR_W'(`RX_RING_BYTES - 1);
    localparam logic [PTR_W-1:0] ALIGN_MASK = PTR_W'(`RX_ALIGN_BYTES - 1);

    logic [PTR_W-1:0] len_ext;      // length widened to pointer size
    logic [PTR_W-1:0] len_rnd;      // length rounded up to a slot
    logic [PTR_W-1:0] ptr_nxt;      // wrapped next pointer

    ////////////////////////////////////////////////////////////
    // next pointer
    ////////////////////////////////////////////////////////////

    // widening first keeps the round up from overflowing the len field
    assign len_ext = PTR_W'(frame_len);

    // add align-1 then drop the low bits
    assign len_rnd = (len_ext + ALIGN_MASK) & ~ALIGN_MASK;

    // zero length gives len_rnd zero and the pointer stays put
    // modulo ring size by keeping the low bits only
    assign ptr_nxt = (hw_ptr + len_rnd) & RING_MASK;

    ////////////////////////////////////////////////////////////
    // pointer register
    ////////////////////////////////////////////////////////////

    // updates on the edge that samples the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            hw_ptr <= '0;                       // ring starts empty
        end else if (frame_done) begin
            hw_ptr <= ptr_nxt;
        end
    end

    // hw_ptr stays aligned and inside the ring because
    // it starts at zero, len_rnd is aligned and the mask
    // keeps only in-ring bits

endmodule

// File: verilog/rx_irq_gen.sv
// rx interrupt generator
// two flop synchronizer on the async mac activity flag
// three state fsm driving the level interrupt line
`include "rx_dma_settings.svh"

module rx_irq_gen (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mac_activity,   // async from mac
    input  logic                      hst_rdy,        // ctrl.host_ready
    input  logic [`RX_PTR_W-1:0]      hw_ptr,         // ring write side
    input  logic [`RX_PTR_W-1:0]      sw_ptr,         // ring read side
    output logic                      send_irq,       // level interrupt
    output rx_dma_pkg::rx_irq_state_e irq_state
);

    logic act_meta;     // first sync stage, may go metastable
    logic act_sync;     // second sync stage, safe to use
    logic ptr_diff;     // host has unread frames

    ////////////////////////////////////////////////////////////
    // activity synchronizer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            act_meta <= 1'b0;
            act_sync <= 1'b0;
        end else begin
            act_meta <= mac_activity;
            act_sync <= act_meta;
        end
    end

    assign ptr_diff = (hw_ptr != sw_ptr);

    ////////////////////////////////////////////////////////////
    // interrupt fsm
    ////////////////////////////////////////////////////////////

    // only reset brings the fsm back to idle
    // dropping hst_rdy later does not disarm it
    always_ff @(posedge clk) begin
        if (rst) begin
            send_irq  <= 1'b0;
            irq_state <= rx_dma_pkg::irq_idle;
        end else begin
            case (irq_state)
                rx_dma_pkg::irq_idle: begin
                    send_irq <= 1'b0;
                    if (hst_rdy) begin
                        irq_state <= rx_dma_pkg::irq_wait_activity;   // armed
                    end
                end
                rx_dma_pkg::irq_wait_activity: begin
                    if (act_sync) begin
                        send_irq  <= 1'b1;      // first rx seen
                        irq_state <= rx_dma_pkg::irq_active;
                    end
                end
                rx_dma_pkg::irq_active: begin
                    // held while new traffic or unread data
                    send_irq <= act_sync | ptr_diff;
                end
                default: begin
                    send_irq  <= 1'b0;          // bad encoding
                    irq_state <= rx_dma_pkg::irq_idle;
                end
            endcase
        end
    end

endmodule

// File: verilog/rx_dma_pkg.sv
// shared types of the rx dma interrupt path
// apb register word union with control and pointer views
// interrupt fsm state encoding
`include "rx_dma_settings.svh"

package rx_dma_pkg;

    ////////////////////////////////////////////////////////////
    // register word
    ////////////////////////////////////////////////////////////

    // one apb data word, decoded per register address
    typedef union packed {
        struct packed {
            logic [`APB_DATA_W-2:0] rsvd;         // reads back zero
            logic                   host_ready;   // arms the irq fsm
        } ctrl;
        logic [`APB_DATA_W-1:0] ptr;              // raw ring byte pointer
    } rx_reg_word_u;

    ////////////////////////////////////////////////////////////
    // interrupt generator states
    ////////////////////////////////////////////////////////////

    // 2'b11 unused, fsm falls back to idle
    typedef enum logic [1:0] {
        irq_idle          = 2'b00,  // host not ready yet
        irq_wait_activity = 2'b01,  // armed, no rx seen
        irq_active        = 2'b10   // line tracks activity and pointers
    } rx_irq_state_e;

endpackage

// File: include/rx_dma_settings.svh
// rx dma interrupt path settings
// ring pointer geometry and frame length field
// apb bus widths and register map offsets
`ifndef RX_DMA_SETTINGS_SVH
`define RX_DMA_SETTINGS_SVH

////////////////////////////////////////////////////////////
// ring geometry
////////////////////////////////////////////////////////////
`define RX_PTR_W        32      // byte pointer, fits one apb word
`define RX_RING_BYTES   4096    // power of two ring size
`define RX_ALIGN_BYTES  8       // frame slot granularity
`define RX_LEN_W        16      // frame length in bytes

// apb slave bus
`define APB_ADDR_W      12
`define APB_DATA_W      32

////////////////////////////////////////////////////////////
// register offsets
////////////////////////////////////////////////////////////
`define RX_REG_CTRL     'h00    // host_ready in bit 0
`define RX_REG_SW_PTR   'h04    // software read pointer
`define RX_REG_HW_PTR   'h08    // read only hw write pointer
`define RX_REG_STATUS   'h0C    // read only irq fsm state

`endif
